// File: dv/l1_cache_assert.sv
module l1_cache_assert (
	input logic                   clock_i,
	input logic                   resetn_i,
	input logic                   core_req_ready_i,
	input logic                   core_done_i,
	input logic                   mem_cmd_valid_i,
	input logic                   mem_cmd_ready_i,
	input l1_cache_pkg::mem_cmd_t mem_cmd_i,
	input logic                   multi_hit_i
);

	int unsigned fail_count = 0;  // failed assertions so far

	// ----------------------------------------------------------------------
	// handshake rules
	// ----------------------------------------------------------------------
	cmd_held_a: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_cmd_valid_i && !mem_cmd_ready_i |=> mem_cmd_valid_i && $stable(mem_cmd_i))
		else begin
			fail_count++;
			$error("memory command dropped or changed before ready");
		end
	done_pulse_a: assert property (@(posedge clock_i) disable iff (!resetn_i)
		core_done_i |=> !core_done_i)
		else begin
			fail_count++;
			$error("core done longer than one cycle");
		end
	done_busy_a: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(core_done_i && core_req_ready_i))
		else begin
			fail_count++;
			$error("core done while ready for a new request");
		end

	// error flag of the way merger
	one_hit_a: assert property (@(posedge clock_i) disable iff (!resetn_i) !multi_hit_i)
		else begin
			fail_count++;
			$error("same block hits in two ways");
		end

endmodule

bind l1_cache_top l1_cache_assert u_assert (
	.clock_i, .resetn_i,
	.core_req_ready_i(core_req_ready_o), .core_done_i(core_done_o),
	.mem_cmd_valid_i(mem_cmd_valid_o), .mem_cmd_ready_i, .mem_cmd_i(mem_cmd_o),
	.multi_hit_i(u_merge.multi_hit)
);

// File: dv/l1_cache_tb.sv
`include "l1_cache_settings.svh"

module l1_cache_tb;
	import l1_cache_pkg::*;

	localparam int SETS      = 1 << `L1C_SET_BITS;
	localparam int MEM_WORDS = 1 << `L1C_ADDR_W;
	localparam int TIMEOUT   = 4000;          // both passes at worst-case delays plus margin
	localparam logic [31:0] MEM_KEY = 32'h5a5a_c3c3;

	logic      clock_i = 1'b0;
	logic      resetn_i;
	logic      core_req_valid_i, core_req_ready_o, core_done_o;
	core_req_t core_req_i;
	core_rsp_t core_rsp_o;
	logic      mem_cmd_valid_o, mem_cmd_ready_i, mem_wvalid_o, mem_wready_i;
	logic      mem_rvalid_i, mem_rready_o;
	mem_cmd_t  mem_cmd_o;
	data_t     mem_wdata_o, mem_rdata_i;

	data_t     mem [MEM_WORDS];     // memory model contents
	data_t     golden [MEM_WORDS];  // what a load must return
	tag_t      ref_tag [SETS][`L1C_WAYS];
	logic      ref_valid [SETS][`L1C_WAYS];
	logic      ref_dirty [SETS][`L1C_WAYS];
	way_idx_t  ref_lru [SETS];      // lru way per set
	mem_cmd_t  exp_cmd_q [$];
	data_t     exp_wdata_q [$];
	int        seed = 69762;
	int        cycles = 0;
	logic      rand_delays = 1'b0;

	l1_cache_top uut (.*);

	always #2 clock_i = ~clock_i;

	// ----------------------------------------------------------------------
	// helpers and compare tasks
	// ----------------------------------------------------------------------
	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_rsp(input string name, input core_rsp_t exp, input core_rsp_t got);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t: %s expected hit %b data %h, got hit %b data %h",
				$time, name, exp.hit, exp.rdata, got.hit, got.rdata));
		end
	endtask

	task automatic check_cmd(input string name, input mem_cmd_t exp, input mem_cmd_t got);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t: %s expected rw %b addr %h, got rw %b addr %h",
				$time, name, exp.rw, exp.addr, got.rw, got.addr));
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t got);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t: %s expected %h got %h",
				$time, name, exp, got));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, exp, got));
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int got);
		if (got != exp) begin
			fail_now($sformatf("mismatch at %0t: %s expected %0d got %0d",
				$time, name, exp, got));
		end
	endtask

	function automatic int mem_delay();
		return rand_delays ? ($random(seed) & 3) : 0;  // 0 to 3 wait cycles
	endfunction

	function automatic addr_t make_addr(input int tag, input int set, input int off);
		addr_t a;
		a.tag    = tag_t'(tag);
		a.set    = set_t'(set);
		a.offset = offset_t'(off);
		return a;
	endfunction

	// ----------------------------------------------------------------------
	// memory model serving one command and its four words at a time
	// ----------------------------------------------------------------------
	initial begin : mem_model
		mem_cmd_t cmd;
		int       base;
		mem_cmd_ready_i = 1'b0;
		mem_wready_i    = 1'b0;
		mem_rvalid_i    = 1'b0;
		mem_rdata_i     = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a]    = data_t'(a) ^ MEM_KEY;
			golden[a] = data_t'(a) ^ MEM_KEY;
		end
		@(posedge resetn_i);
		forever begin
			@(negedge clock_i);
			if (mem_cmd_valid_o) begin
				repeat (mem_delay()) @(negedge clock_i);
				cmd  = mem_cmd_o;
				base = cmd.addr;
				if (exp_cmd_q.size() == 0) fail_now("memory command issued where none was expected");
				check_cmd("mem_cmd_o", exp_cmd_q.pop_front(), cmd);
				mem_cmd_ready_i = 1'b1;
				@(negedge clock_i);
				mem_cmd_ready_i = 1'b0;
				for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
					repeat (mem_delay()) @(negedge clock_i);
					if (cmd.rw) begin
						check_flag("mem_wvalid_o", 1'b1, mem_wvalid_o);
						check_data("mem_wdata_o", exp_wdata_q.pop_front(), mem_wdata_o);
						mem[base + i] = mem_wdata_o;
						mem_wready_i  = 1'b1;
					end else begin
						check_flag("mem_rready_o", 1'b1, mem_rready_o);
						mem_rdata_i  = mem[base + i];  // words in offset order
						mem_rvalid_i = 1'b1;
					end
					@(negedge clock_i);
					mem_wready_i = 1'b0;
					mem_rvalid_i = 1'b0;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// one core access with the reference prediction before drive and compare
	// ----------------------------------------------------------------------
	task automatic access(input logic rw, input addr_t addr, input data_t wdata);
		core_rsp_t exp_rsp;
		mem_cmd_t  cmd;
		set_t      s;
		int        way;
		int        a;
		int        base;
		int        lat;
		s   = addr.set;
		a   = addr;
		way = -1;
		for (int w = `L1C_WAYS - 1; w >= 0; w--) begin
			if (ref_valid[s][w] && ref_tag[s][w] == addr.tag) way = w;  // lowest way wins
		end
		exp_rsp.hit = (way >= 0);
		if (way < 0) begin
			way = ref_lru[s];
			for (int w = `L1C_WAYS - 1; w >= 0; w--) begin
				if (!ref_valid[s][w]) way = w;  // first invalid way before lru
			end
			if (ref_valid[s][way] && ref_dirty[s][way]) begin
				cmd.rw   = 1'b1;
				cmd.addr = make_addr(ref_tag[s][way], s, 0);
				base     = cmd.addr;
				exp_cmd_q.push_back(cmd);
				for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
					exp_wdata_q.push_back(golden[base + i]);
				end
			end
			cmd.rw   = 1'b0;
			cmd.addr = make_addr(addr.tag, s, 0);  // fill at block address
			exp_cmd_q.push_back(cmd);
			ref_tag[s][way]   = addr.tag;
			ref_valid[s][way] = 1'b1;
			ref_dirty[s][way] = 1'b0;
		end
		if (rw) begin
			golden[a]         = wdata;
			ref_dirty[s][way] = 1'b1;
		end
		exp_rsp.rdata = golden[a];  // a store echoes its word
		ref_lru[s]    = ~way_idx_t'(way);
		@(negedge clock_i);
		check_flag("core_req_ready_o", 1'b1, core_req_ready_o);
		core_req_valid_i = 1'b1;
		core_req_i.rw    = rw;
		core_req_i.addr  = addr;
		core_req_i.wdata = wdata;
		@(negedge clock_i);
		core_req_valid_i = 1'b0;
		lat = 1;
		while (!core_done_o) begin
			@(negedge clock_i);
			lat++;
		end
		check_rsp("core_rsp_o", exp_rsp, core_rsp_o);
		if (exp_rsp.hit) check_cycles("hit latency", 2, lat);
		if (exp_cmd_q.size() != 0) fail_now("expected memory command was never issued");
		if (exp_wdata_q.size() != 0) fail_now("write-back words were left unsent");
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic reset_outputs();
		check_flag("core_req_ready_o", 1'b1, core_req_ready_o);
		check_flag("core_done_o", 1'b0, core_done_o);
		check_flag("mem_cmd_valid_o", 1'b0, mem_cmd_valid_o);
		check_flag("mem_wvalid_o", 1'b0, mem_wvalid_o);
		check_flag("mem_rready_o", 1'b0, mem_rready_o);
	endtask

	task automatic read_miss_then_hit(input int tag);
		access(1'b0, make_addr(tag, 1, 2), '0);  // miss and fill
		access(1'b0, make_addr(tag, 1, 3), '0);  // same block
	endtask

	task automatic store_then_load(input int tag);
		access(1'b1, make_addr(tag, 1, 0), data_t'($random(seed)));
		access(1'b0, make_addr(tag, 1, 0), '0);
		access(1'b0, make_addr(tag, 1, 1), '0);  // neighbour untouched
	endtask

	task automatic lru_replacement(input int tag);
		access(1'b0, make_addr(tag, 2, 0), '0);      // A
		access(1'b0, make_addr(tag + 1, 2, 1), '0);  // B
		access(1'b0, make_addr(tag, 2, 2), '0);      // A again so B becomes lru
		access(1'b0, make_addr(tag + 2, 2, 3), '0);  // C evicts B
		access(1'b0, make_addr(tag, 2, 0), '0);
		access(1'b0, make_addr(tag + 1, 2, 1), '0);
	endtask

	task automatic dirty_writeback(input int tag);
		access(1'b1, make_addr(tag, 3, 1), data_t'($random(seed)));  // X dirty
		access(1'b0, make_addr(tag + 1, 3, 0), '0);                  // Y clean
		access(1'b0, make_addr(tag, 3, 1), '0);
		access(1'b0, make_addr(tag + 2, 3, 0), '0);  // Z evicts Y without a write
		access(1'b0, make_addr(tag + 1, 3, 2), '0);  // X written back
		access(1'b0, make_addr(tag, 3, 1), '0);      // refill sees stored word
	endtask

	task automatic run_all(input int tag_base);
		read_miss_then_hit(tag_base);
		store_then_load(tag_base);
		lru_replacement(tag_base + 4);
		dirty_writeback(tag_base + 8);
	endtask

	// watchdog and assertion watch
	always @(posedge clock_i) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			fail_now($sformatf("timeout after %0d cycles, DUT stopped answering", cycles));
		end
	end

	always @(negedge clock_i) begin
		if (uut.u_assert.fail_count != 0) fail_now("a handshake assertion failed");
	end

	initial begin
		resetn_i         = 1'b0;
		core_req_valid_i = 1'b0;
		core_req_i       = '0;
		for (int s = 0; s < SETS; s++) begin
			ref_lru[s] = '0;
			for (int w = 0; w < `L1C_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
		repeat (3) @(negedge clock_i);
		resetn_i = 1'b1;
		reset_outputs();
		run_all(16);     // memory answers at once
		rand_delays = 1'b1;
		run_all(512);    // fresh tags under random back-pressure
		repeat (2) @(negedge clock_i);
		if (uut.u_assert.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: l1_cache.f
+incdir+logic
logic/l1_cache_pkg.sv
logic/cache_way.sv
logic/lru_victim_select.sv
logic/way_hit_merge.sv
logic/miss_sequencer.sv
logic/l1_cache_top.sv
dv/l1_cache_assert.sv
dv/l1_cache_tb.sv

// File: logic/cache_way.sv
`include "l1_cache_settings.svh"

module cache_way (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  l1_cache_pkg::way_cmd_t  cmd_i,
	output l1_cache_pkg::way_view_t view_o
);
	import l1_cache_pkg::*;

	localparam int SETS  = 1 << `L1C_SET_BITS;
	localparam int WORDS = SETS * WORDS_PER_BLOCK;

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	tag_t            tag_q [SETS];
	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;
	data_t           data_q [WORDS];

	logic [`L1C_SET_BITS+`L1C_OFFSET_BITS-1:0] word_idx;

	assign word_idx = {cmd_i.set, cmd_i.offset}; // set major, word minor

	// line state flags
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (cmd_i.wr_tag) begin
				valid_q[cmd_i.set] <= 1'b1;  // tag lands with last fill word
			end
			// store wins over a clear, both never come together
			if (cmd_i.set_dirty) begin
				dirty_q[cmd_i.set] <= 1'b1;
			end else if (cmd_i.clr_dirty) begin
				dirty_q[cmd_i.set] <= 1'b0;
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge clock_i) begin
		if (cmd_i.wr_tag) begin
			tag_q[cmd_i.set] <= cmd_i.tag;
		end
		if (cmd_i.wr_word) begin
			data_q[word_idx] <= cmd_i.wdata;
		end
	end

	// ----------------------------------------------------------------------
	// read side, straight from the current command
	// ----------------------------------------------------------------------
	always_comb begin
		view_o.valid = valid_q[cmd_i.set];
		view_o.dirty = dirty_q[cmd_i.set];
		view_o.tag   = tag_q[cmd_i.set];
		view_o.rdata = data_q[word_idx];  // old word during a write
	end

endmodule

// File: logic/l1_cache_pkg.sv
`include "l1_cache_settings.svh"

package l1_cache_pkg;

	// derived widths
	localparam int TAG_W = `L1C_ADDR_W - `L1C_SET_BITS - `L1C_OFFSET_BITS;
	localparam int WORDS_PER_BLOCK = 1 << `L1C_OFFSET_BITS;

	typedef logic [TAG_W-1:0]              tag_t;
	typedef logic [`L1C_SET_BITS-1:0]      set_t;
	typedef logic [`L1C_OFFSET_BITS-1:0]   offset_t;
	typedef logic [`L1C_DATA_W-1:0]        data_t;
	typedef logic [$clog2(`L1C_WAYS)-1:0]  way_idx_t;

	// word address split into its fields, tag on top
	typedef struct packed {
		tag_t    tag;
		set_t    set;
		offset_t offset;
	} addr_t;

	// bus payloads
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic  rw;      // 1 = store
		addr_t addr;
		data_t wdata;
	} core_req_t;

	typedef struct packed {
		logic  hit;     // block present at first lookup
		data_t rdata;
	} core_rsp_t;

	typedef struct packed {
		logic  rw;      // 1 = write-back, 0 = fill
		addr_t addr;    // block aligned
	} mem_cmd_t;

	// per way access
	// ----------------------------------------------------------------------
	typedef struct packed {
		set_t    set;
		offset_t offset;
		tag_t    tag;
		data_t   wdata;
		logic    wr_word;
		logic    wr_tag;      // also sets valid
		logic    set_dirty;
		logic    clr_dirty;
	} way_cmd_t;

	typedef struct packed {
		logic  valid;
		logic  dirty;
		tag_t  tag;
		data_t rdata;
	} way_view_t;

	// what the sequencer asks of the ways this cycle
	typedef enum logic [2:0] {
		STG_READ,     // plain read at the request word
		STG_WB,       // read victim word for write-back
		STG_WB_LAST,  // last write-back word, victim goes clean
		STG_FILL,     // write fill word into victim
		STG_RESPOND   // store write on hit way, lru update
	} stage_e;

endpackage

// File: logic/l1_cache_settings.svh
`ifndef L1_CACHE_SETTINGS_SVH
`define L1_CACHE_SETTINGS_SVH

// address and data sizing
`define L1C_ADDR_W 16       // word address, not byte
`define L1C_DATA_W 32

// cache geometry
// --------------------------------------------------------------------------
`define L1C_OFFSET_BITS 2   // 4 words per block
`define L1C_SET_BITS 3      // 8 sets

// associativity, the lru scheme only covers two ways
`define L1C_WAYS 2

`endif

// File: logic/l1_cache_top.sv
`include "l1_cache_settings.svh"

module l1_cache_top (
	input  logic                    clock_i,
	input  logic                    resetn_i,

	input  logic                    core_req_valid_i,
	input  l1_cache_pkg::core_req_t core_req_i,
	output logic                    core_req_ready_o,
	output logic                    core_done_o,
	output l1_cache_pkg::core_rsp_t core_rsp_o,

	output logic                    mem_cmd_valid_o,
	output l1_cache_pkg::mem_cmd_t  mem_cmd_o,
	input  logic                    mem_cmd_ready_i,
	output logic                    mem_wvalid_o,
	output l1_cache_pkg::data_t     mem_wdata_o,
	input  logic                    mem_wready_i,
	input  logic                    mem_rvalid_i,
	input  l1_cache_pkg::data_t     mem_rdata_i,
	output logic                    mem_rready_o
);
	import l1_cache_pkg::*;

	stage_e               stage;
	core_req_t            req;
	offset_t              word;
	data_t                fill_data;
	way_idx_t             resp_way;    // hit way held by the sequencer
	logic                 hit;
	way_idx_t             hit_way;
	data_t                hit_data;
	way_view_t            victim_view;
	way_idx_t             victim_way;
	logic [`L1C_WAYS-1:0] view_valid;
	way_cmd_t             way_cmds [`L1C_WAYS];
	way_view_t            way_views [`L1C_WAYS];

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------
	miss_sequencer u_seq (
		.clock_i, .resetn_i,
		.core_req_valid_i, .core_req_i, .core_req_ready_o, .core_done_o, .core_rsp_o,
		.mem_cmd_valid_o, .mem_cmd_o, .mem_cmd_ready_i,
		.mem_wvalid_o, .mem_wdata_o, .mem_wready_i,
		.mem_rvalid_i, .mem_rdata_i, .mem_rready_o,
		.hit_i(hit), .hit_way_i(hit_way), .hit_data_i(hit_data),
		.victim_view_i(victim_view), .stage_o(stage), .req_o(req), .word_o(word),
		.fill_data_o(fill_data), .hit_way_o(resp_way)
	);

	lru_victim_select u_lru (
		.clock_i, .resetn_i,
		.stage_i(stage), .req_i(req), .word_i(word), .fill_data_i(fill_data),
		.hit_way_i(resp_way), .view_valid_i(view_valid),
		.victim_way_o(victim_way), .way_cmd_o(way_cmds)
	);

	// storage, one instance per way
	for (genvar i = 0; i < `L1C_WAYS; i++) begin : way_gen
		cache_way u_way (
			.clock_i, .resetn_i,
			.cmd_i(way_cmds[i]), .view_o(way_views[i])
		);
		assign view_valid[i] = way_views[i].valid;
	end

	way_hit_merge u_merge (
		.views_i(way_views), .tag_i(req.addr.tag), .victim_way_i(victim_way),
		.hit_o(hit), .hit_way_o(hit_way), .hit_data_o(hit_data),
		.victim_view_o(victim_view)
	);

endmodule

// File: logic/lru_victim_select.sv
`include "l1_cache_settings.svh"

module lru_victim_select (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  l1_cache_pkg::stage_e    stage_i,
	input  l1_cache_pkg::core_req_t req_i,
	input  l1_cache_pkg::offset_t   word_i,
	input  l1_cache_pkg::data_t     fill_data_i,
	input  l1_cache_pkg::way_idx_t  hit_way_i,
	input  logic [`L1C_WAYS-1:0]    view_valid_i,
	output l1_cache_pkg::way_idx_t  victim_way_o,
	output l1_cache_pkg::way_cmd_t  way_cmd_o [`L1C_WAYS]
);
	import l1_cache_pkg::*;

	localparam int SETS = 1 << `L1C_SET_BITS;

	logic [SETS-1:0] lru_q;   // per set, number of the lru way
	logic            block_op; // word counter drives the offset
	logic            fill_en;
	logic            store_en;
	logic            last_word;

	assign block_op  = (stage_i == STG_WB) || (stage_i == STG_WB_LAST) || (stage_i == STG_FILL);
	assign fill_en   = (stage_i == STG_FILL);
	assign store_en  = (stage_i == STG_RESPOND) && req_i.rw;
	assign last_word = (word_i == offset_t'(WORDS_PER_BLOCK - 1));

	// lowest invalid way first, else the lru one
	always_comb begin
		victim_way_o = lru_q[req_i.addr.set];
		for (int w = `L1C_WAYS - 1; w >= 0; w--) begin
			if (!view_valid_i[w]) begin
				victim_way_o = way_idx_t'(w);
			end
		end
	end

	// the way just used becomes mru
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			lru_q <= '0;
		end else if (stage_i == STG_RESPOND) begin
			lru_q[req_i.addr.set] <= ~hit_way_i;
		end
	end

	// ----------------------------------------------------------------------
	// per way commands, same address to all, enables steered
	// ----------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < `L1C_WAYS; w++) begin
			way_cmd_o[w].set    = req_i.addr.set;
			way_cmd_o[w].offset = block_op ? word_i : req_i.addr.offset;
			way_cmd_o[w].tag    = req_i.addr.tag;
			way_cmd_o[w].wdata  = fill_en ? fill_data_i : req_i.wdata;
			way_cmd_o[w].wr_word = (fill_en && victim_way_o == way_idx_t'(w))
				|| (store_en && hit_way_i == way_idx_t'(w));
			way_cmd_o[w].wr_tag = fill_en && last_word && victim_way_o == way_idx_t'(w);
			way_cmd_o[w].set_dirty = store_en && hit_way_i == way_idx_t'(w);
			way_cmd_o[w].clr_dirty = (stage_i == STG_WB_LAST) && victim_way_o == way_idx_t'(w);
		end
	end

endmodule

// File: logic/miss_sequencer.sv
module miss_sequencer (
	input  logic                    clock_i,
	input  logic                    resetn_i,

	// core side
	input  logic                    core_req_valid_i,
	input  l1_cache_pkg::core_req_t core_req_i,
	output logic                    core_req_ready_o,
	output logic                    core_done_o,
	output l1_cache_pkg::core_rsp_t core_rsp_o,

	// memory side
	output logic                    mem_cmd_valid_o,
	output l1_cache_pkg::mem_cmd_t  mem_cmd_o,
	input  logic                    mem_cmd_ready_i,
	output logic                    mem_wvalid_o,
	output l1_cache_pkg::data_t     mem_wdata_o,
	input  logic                    mem_wready_i,
	input  logic                    mem_rvalid_i,
	input  l1_cache_pkg::data_t     mem_rdata_i,
	output logic                    mem_rready_o,

	// way side
	input  logic                    hit_i,
	input  l1_cache_pkg::way_idx_t  hit_way_i,
	input  l1_cache_pkg::data_t     hit_data_i,
	input  l1_cache_pkg::way_view_t victim_view_i,
	output l1_cache_pkg::stage_e    stage_o,
	output l1_cache_pkg::core_req_t req_o,
	output l1_cache_pkg::offset_t   word_o,
	output l1_cache_pkg::data_t     fill_data_o,
	output l1_cache_pkg::way_idx_t  hit_way_o
);
	import l1_cache_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WB_CMD,
		S_WB_DATA,
		S_FILL_CMD,
		S_FILL_DATA,
		S_RESPOND
	} state_e;

	state_e    state_q;
	offset_t   word_q;     // word counter for write-back and fill
	logic      missed_q;   // first lookup missed
	core_req_t req_q;
	core_rsp_t rsp_q;
	mem_cmd_t  cmd_q;
	way_idx_t  hit_way_q;
	mem_cmd_t  wb_cmd;
	mem_cmd_t  fill_cmd;
	logic      need_wb;
	logic      last_word;

	assign need_wb   = victim_view_i.valid && victim_view_i.dirty;
	assign last_word = (word_q == offset_t'(WORDS_PER_BLOCK - 1));

	// block addresses, victim's own tag for write-back
	always_comb begin
		wb_cmd.rw            = 1'b1;
		wb_cmd.addr.tag      = victim_view_i.tag;
		wb_cmd.addr.set      = req_q.addr.set;
		wb_cmd.addr.offset   = '0;
		fill_cmd.rw          = 1'b0;
		fill_cmd.addr        = req_q.addr;
		fill_cmd.addr.offset = '0;
	end

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q  <= S_IDLE;
			word_q   <= '0;
			missed_q <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: if (core_req_valid_i) begin
					missed_q <= 1'b0;
					state_q  <= S_LOOKUP;
				end
				S_LOOKUP: if (hit_i) begin
					state_q <= S_RESPOND;
				end else begin
					missed_q <= 1'b1;
					state_q  <= need_wb ? S_WB_CMD : S_FILL_CMD;
				end
				S_WB_CMD: if (mem_cmd_ready_i) begin
					state_q <= S_WB_DATA;
				end
				S_WB_DATA: if (mem_wready_i) begin
					word_q <= word_q + 1'b1;  // wraps to 0 after last
					if (last_word) begin
						state_q <= S_FILL_CMD;
					end
				end
				S_FILL_CMD: if (mem_cmd_ready_i) begin
					state_q <= S_FILL_DATA;
				end
				S_FILL_DATA: if (mem_rvalid_i) begin
					word_q <= word_q + 1'b1;
					if (last_word) begin
						state_q <= S_LOOKUP;  // second lookup hits
					end
				end
				S_RESPOND: state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// request, response and command payload
	always_ff @(posedge clock_i) begin
		if (state_q == S_IDLE && core_req_valid_i) begin
			req_q <= core_req_i;
		end
		if (state_q == S_LOOKUP) begin
			if (hit_i) begin
				hit_way_q   <= hit_way_i;
				rsp_q.hit   <= !missed_q;
				rsp_q.rdata <= req_q.rw ? req_q.wdata : hit_data_i; // store echoes its word
			end else begin
				cmd_q <= need_wb ? wb_cmd : fill_cmd;
			end
		end
		if (state_q == S_WB_DATA && mem_wready_i && last_word) begin
			cmd_q <= fill_cmd;
		end
	end

	// what the ways do this cycle
	always_comb begin
		case (state_q)
			S_WB_CMD:    stage_o = STG_WB;
			S_WB_DATA:   stage_o = (mem_wready_i && last_word) ? STG_WB_LAST : STG_WB;
			S_FILL_DATA: stage_o = mem_rvalid_i ? STG_FILL : STG_READ;
			S_RESPOND:   stage_o = STG_RESPOND;
			default:     stage_o = STG_READ;
		endcase
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign core_req_ready_o = (state_q == S_IDLE);
	assign core_done_o      = (state_q == S_RESPOND);
	assign core_rsp_o       = rsp_q;
	assign mem_cmd_valid_o  = (state_q == S_WB_CMD) || (state_q == S_FILL_CMD);
	assign mem_cmd_o        = cmd_q;
	assign mem_wvalid_o     = (state_q == S_WB_DATA);
	assign mem_wdata_o      = victim_view_i.rdata;  // victim word at counter
	assign mem_rready_o     = (state_q == S_FILL_DATA);
	assign fill_data_o      = mem_rdata_i;
	assign hit_way_o        = hit_way_q;
	assign req_o            = req_q;
	assign word_o           = word_q;

endmodule

// File: logic/way_hit_merge.sv
`include "l1_cache_settings.svh"

module way_hit_merge (
	input  l1_cache_pkg::way_view_t views_i [`L1C_WAYS],
	input  l1_cache_pkg::tag_t      tag_i,
	input  l1_cache_pkg::way_idx_t  victim_way_i,
	output logic                    hit_o,
	output l1_cache_pkg::way_idx_t  hit_way_o,
	output l1_cache_pkg::data_t     hit_data_o,
	output l1_cache_pkg::way_view_t victim_view_o
);
	import l1_cache_pkg::*;

	logic [`L1C_WAYS-1:0] hit_vec;   // one bit per matching way
	logic                 multi_hit; // error, a block sits in two ways

	// tag compare, only valid lines count
	always_comb begin
		for (int w = 0; w < `L1C_WAYS; w++) begin
			hit_vec[w] = views_i[w].valid && (views_i[w].tag == tag_i);
		end
	end

	assign hit_o     = |hit_vec;
	assign multi_hit = !$onehot0(hit_vec);

	// priority encode, lowest way wins
	always_comb begin
		hit_way_o = '0;
		for (int w = `L1C_WAYS - 1; w >= 0; w--) begin
			if (hit_vec[w]) begin
				hit_way_o = way_idx_t'(w);
			end
		end
	end

	// ----------------------------------------------------------------------
	// data muxes
	// ----------------------------------------------------------------------
	assign hit_data_o    = views_i[hit_way_o].rdata; // don't care on a miss
	assign victim_view_o = views_i[victim_way_i];    // feeds write-back

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the L1 cache testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module l1_cache_tb -f l1_cache.f \
	-o l1_cache_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/l1_cache_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
